// File: hw/tuner_pkg.sv
package tuner_pkg;

	// --------------------------------------------------
	// Scan geometry
	// --------------------------------------------------
	localparam int SEMITONE_COUNT = 49;   // E1 up to E5
	localparam int INDEX_W        = 6;
	localparam int LAST_REGION    = 47;   // Region 47 spans Eb5 to E5

	// Period in nanoseconds
	typedef logic [33:0] period_t;

	// Half width of the on-pitch window
	localparam period_t PITCH_WINDOW = 34'd20000;

	// --------------------------------------------------
	// Output codes
	// --------------------------------------------------
	typedef enum logic [4:0] {
		NOTE_NONE = 5'd0,
		NOTE_C    = 5'd1,
		NOTE_D    = 5'd2,
		NOTE_E    = 5'd3,
		NOTE_F    = 5'd4,
		NOTE_G    = 5'd5,
		NOTE_A    = 5'd6,
		NOTE_B    = 5'd7
	} note_name_e;

	typedef enum logic [3:0] {
		TONE_DEFAULT = 4'd0,
		FLAT_3       = 4'd1,   // Just below the flat semitone
		FLAT_2       = 4'd2,
		FLAT_1       = 4'd3,   // Almost on the natural
		ON_PITCH     = 4'd4,
		SHARP_1      = 4'd5,
		SHARP_2      = 4'd6,
		SHARP_3      = 4'd7
	} tone_e;

	// --------------------------------------------------
	// Table and result records
	// --------------------------------------------------
	typedef struct packed {
		period_t    base;      // Semitone period
		period_t    split_b;   // One third toward next semitone
		period_t    split_c;   // Two thirds toward next semitone
		note_name_e letter;
		logic       black;     // Flat semitone
	} pitch_entry_t;

	typedef struct packed {
		note_name_e note;
		tone_e      tone;
	} note_result_t;

	typedef enum logic [1:0] {
		SCAN_IDLE = 2'd0,
		SCAN_RUN  = 2'd1,
		SCAN_DONE = 2'd2
	} scan_state_e;

endpackage

// File: hw/pitch_table.sv
`timescale 1ns/10ps

module pitch_table import tuner_pkg::*; (
	input  logic [INDEX_W-1:0] index,
	output pitch_entry_t       cur_entry,
	output pitch_entry_t       next_entry
);

	logic [INDEX_W-1:0] next_index;

	function automatic pitch_entry_t mk(
		input int unsigned base,
		input int unsigned split_b,
		input int unsigned split_c,
		input note_name_e  letter,
		input logic        black
	);
		pitch_entry_t e;
		e.base    = period_t'(base);
		e.split_b = period_t'(split_b);
		e.split_c = period_t'(split_c);
		e.letter  = letter;
		e.black   = black;
		return e;
	endfunction

	// --------------------------------------------------
	// Semitone grid, longest period first
	// --------------------------------------------------
	function automatic pitch_entry_t entry_at(input logic [INDEX_W-1:0] idx);
		pitch_entry_t e;
		case (idx)
			6'd0:  e = mk(24270000, 23816000, 23361000, NOTE_E, 1'b0); // E1
			6'd1:  e = mk(22907000, 22479000, 22050000, NOTE_F, 1'b0);
			6'd2:  e = mk(21622000, 21217000, 20813000, NOTE_G, 1'b1);
			6'd3:  e = mk(20408000, 20026000, 19645000, NOTE_G, 1'b0);
			6'd4:  e = mk(19263000, 18903000, 18542000, NOTE_A, 1'b1);
			6'd5:  e = mk(18182000, 17842000, 17501000, NOTE_A, 1'b0);
			6'd6:  e = mk(17161000, 16840000, 16519000, NOTE_B, 1'b1);
			6'd7:  e = mk(16198000, 15895000, 15592000, NOTE_B, 1'b0);
			6'd8:  e = mk(15289000, 15003000, 14717000, NOTE_C, 1'b0); // C2
			6'd9:  e = mk(14431000, 14161000, 13891000, NOTE_D, 1'b1);
			6'd10: e = mk(13621000, 13366000, 13111000, NOTE_D, 1'b0);
			6'd11: e = mk(12856000, 12616000, 12375000, NOTE_E, 1'b1);
			6'd12: e = mk(12135000, 11908000, 11681000, NOTE_E, 1'b0);
			6'd13: e = mk(11454000, 11240000, 11025000, NOTE_F, 1'b0);
			6'd14: e = mk(10811000, 10609000, 10406000, NOTE_G, 1'b1);
			6'd15: e = mk(10204000, 10013000,  9822000, NOTE_G, 1'b0);
			6'd16: e = mk( 9631000,  9451000,  9271000, NOTE_A, 1'b1);
			6'd17: e = mk( 9091000,  8921000,  8751000, NOTE_A, 1'b0);
			6'd18: e = mk( 8581000,  8420000,  8260000, NOTE_B, 1'b1);
			6'd19: e = mk( 8099000,  7947000,  7796000, NOTE_B, 1'b0);
			6'd20: e = mk( 7644000,  7501000,  7358000, NOTE_C, 1'b0); // C3
			6'd21: e = mk( 7215000,  7080000,  6946000, NOTE_D, 1'b1);
			6'd22: e = mk( 6811000,  6683000,  6556000, NOTE_D, 1'b0);
			6'd23: e = mk( 6428000,  6308000,  6187000, NOTE_E, 1'b1);
			6'd24: e = mk( 6067000,  5954000,  5840000, NOTE_E, 1'b0);
			6'd25: e = mk( 5727000,  5620000,  5512000, NOTE_F, 1'b0);
			6'd26: e = mk( 5405000,  5304000,  5203000, NOTE_G, 1'b1);
			6'd27: e = mk( 5102000,  5007000,  4911000, NOTE_G, 1'b0);
			6'd28: e = mk( 4816000,  4726000,  4635000, NOTE_A, 1'b1);
			6'd29: e = mk( 4545000,  4460000,  4375000, NOTE_A, 1'b0);
			6'd30: e = mk( 4290000,  4210000,  4129000, NOTE_B, 1'b1);
			6'd31: e = mk( 4049000,  3973000,  3898000, NOTE_B, 1'b0);
			6'd32: e = mk( 3822000,  3751000,  3679000, NOTE_C, 1'b0); // C4
			6'd33: e = mk( 3608000,  3540000,  3473000, NOTE_D, 1'b1);
			6'd34: e = mk( 3405000,  3341000,  3278000, NOTE_D, 1'b0);
			6'd35: e = mk( 3214000,  3154000,  3094000, NOTE_E, 1'b1);
			6'd36: e = mk( 3034000,  2977000,  2920000, NOTE_E, 1'b0);
			6'd37: e = mk( 2863000,  2810000,  2756000, NOTE_F, 1'b0);
			6'd38: e = mk( 2703000,  2652000,  2602000, NOTE_G, 1'b1);
			6'd39: e = mk( 2551000,  2503000,  2456000, NOTE_G, 1'b0);
			6'd40: e = mk( 2408000,  2363000,  2318000, NOTE_A, 1'b1);
			6'd41: e = mk( 2273000,  2230000,  2188000, NOTE_A, 1'b0); // A4
			6'd42: e = mk( 2145000,  2104000,  2064000, NOTE_B, 1'b1);
			6'd43: e = mk( 2023000,  1986000,  1948000, NOTE_B, 1'b0);
			6'd44: e = mk( 1911000,  1875000,  1840000, NOTE_C, 1'b0); // C5
			6'd45: e = mk( 1804000,  1770000,  1737000, NOTE_D, 1'b1);
			6'd46: e = mk( 1703000,  1671000,  1639000, NOTE_D, 1'b0);
			6'd47: e = mk( 1607000,  1577000,  1547000, NOTE_E, 1'b1);
			// Bottom of the grid, no region below
			6'd48: e = mk( 1517000,  1517000,  1517000, NOTE_E, 1'b0);
			default: e = mk(0, 0, 0, NOTE_NONE, 1'b0);
		endcase
		return e;
	endfunction

	assign next_index = index + INDEX_W'(1);

	// Two read ports, one region per lookup
	assign cur_entry  = entry_at(index);
	assign next_entry = entry_at(next_index);

endmodule

// File: hw/scan_counter.sv
`timescale 1ns/10ps

module scan_counter import tuner_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic               step,
	output logic [INDEX_W-1:0] index,
	output logic               last
);

	localparam logic [INDEX_W-1:0] INDEX_MAX = INDEX_W'(LAST_REGION);

	always_ff @(posedge clk) begin
		if (reset) begin
			index <= '0;
		end else if (start) begin
			index <= '0;               // New search from E1
		end else if (step && !last) begin
			index <= index + INDEX_W'(1);
		end
	end

	assign last = (index == INDEX_MAX);   // Region Eb5 to E5

	// Table holds one entry past the last region
	a_index_range: assert property (@(posedge clk) disable iff (reset)
		index <= INDEX_MAX);

endmodule

// File: hw/scan_fsm.sv
`timescale 1ns/10ps

module scan_fsm import tuner_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic period_valid,
	input  logic hit,
	input  logic last,
	output logic start,
	output logic step,
	output logic finish
);

	scan_state_e state;
	scan_state_e state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SCAN_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			SCAN_IDLE: begin
				if (period_valid) begin
					state_next = SCAN_RUN;
				end
			end
			SCAN_RUN: begin
				if (hit || last) begin   // Found, or grid exhausted
					state_next = SCAN_DONE;
				end
			end
			SCAN_DONE: state_next = SCAN_IDLE;
			default:   state_next = SCAN_IDLE;
		endcase
	end

	// --------------------------------------------------
	// Strobes
	// --------------------------------------------------
	assign start  = (state == SCAN_IDLE) && period_valid;
	assign step   = (state == SCAN_RUN) && !hit && !last;
	assign finish = (state == SCAN_DONE);

	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(start && finish));

	// Every search ends, at most one cycle per semitone
	a_bounded: assert property (@(posedge clk) disable iff (reset)
		start |-> ##[2:SEMITONE_COUNT] finish);

endmodule

// File: hw/pitch_classifier.sv
`timescale 1ns/10ps

module pitch_classifier import tuner_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic         finish,
	input  period_t      period,
	input  pitch_entry_t cur_entry,
	input  pitch_entry_t next_entry,
	output logic         hit,
	output note_result_t result
);

	localparam note_result_t NO_NOTE = '{note: NOTE_NONE, tone: TONE_DEFAULT};

	period_t      period_q;
	logic         busy;
	logic         cur_near;
	logic         next_near;
	logic         in_region;
	note_result_t found;

	function automatic logic near_pitch(input period_t base, input period_t p);
		period_t diff;
		diff = (base > p) ? base - p : p - base;
		return diff < PITCH_WINDOW;
	endfunction

	always_ff @(posedge clk) begin
		if (start) begin
			period_q <= period;
		end
	end

	// --------------------------------------------------
	// Match against the current pair
	// --------------------------------------------------
	assign cur_near  = !cur_entry.black && near_pitch(cur_entry.base, period_q);
	assign next_near = !next_entry.black && near_pitch(next_entry.base, period_q);
	assign in_region = (period_q > next_entry.base) && (period_q <= cur_entry.base);
	assign hit       = cur_near || next_near || in_region;

	always_comb begin
		found = NO_NOTE;
		if (cur_near) begin                  // Window wins over region
			found = '{note: cur_entry.letter, tone: ON_PITCH};
		end else if (next_near) begin
			found = '{note: next_entry.letter, tone: ON_PITCH};
		end else if (in_region) begin
			if (!cur_entry.black) begin
				found.note = cur_entry.letter;    // Sharp of the natural above
				if (period_q > cur_entry.split_b)
					found.tone = SHARP_1;
				else if (period_q > cur_entry.split_c)
					found.tone = SHARP_2;
				else
					found.tone = SHARP_3;
			end else begin
				found.note = next_entry.letter;   // Flat of the natural below
				if (period_q > cur_entry.split_b)
					found.tone = FLAT_3;
				else if (period_q > cur_entry.split_c)
					found.tone = FLAT_2;
				else
					found.tone = FLAT_1;
			end
		end
	end

	// --------------------------------------------------
	// Result register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			result <= NO_NOTE;
		end else begin
			if (start) begin
				busy   <= 1'b1;
				result <= NO_NOTE;      // Already final if nothing matches
			end else if (busy && hit) begin
				result <= found;
			end else if (finish) begin
				result <= NO_NOTE;
			end
			if (finish) begin
				busy <= 1'b0;
			end
		end
	end

	a_hit_named: assert property (@(posedge clk) disable iff (reset)
		busy && hit |=> result.note != NOTE_NONE);

endmodule

// File: hw/note_finder.sv
`timescale 1ns/10ps

module note_finder import tuner_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         period_valid,
	input  period_t      period,
	output logic         result_valid,
	output note_result_t result
);

	logic               start;
	logic               step;
	logic               hit;
	logic               last;
	logic [INDEX_W-1:0] index;
	pitch_entry_t       cur_entry;
	pitch_entry_t       next_entry;

	// --------------------------------------------------
	// Control
	// --------------------------------------------------
	scan_fsm scan_fsm_i (
		.clk          (clk),
		.reset        (reset),
		.period_valid (period_valid),
		.hit          (hit),
		.last         (last),
		.start        (start),
		.step         (step),
		.finish       (result_valid)   // One pulse per search
	);

	scan_counter scan_counter_i (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.step  (step),
		.index (index),
		.last  (last)
	);

	// --------------------------------------------------
	// Data path
	// --------------------------------------------------
	pitch_table pitch_table_i (
		.index      (index),
		.cur_entry  (cur_entry),
		.next_entry (next_entry)
	);

	pitch_classifier pitch_classifier_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.finish     (result_valid),
		.period     (period),
		.cur_entry  (cur_entry),
		.next_entry (next_entry),
		.hit        (hit),
		.result     (result)
	);

endmodule

// File: dv/note_finder_tb.sv
`timescale 1ns/10ps

module note_finder_tb import tuner_pkg::*; ();

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 8;
	localparam int WAIT_CYCLES     = 60;   // Bound on one search
	localparam int JITTER_LIMIT    = 19000;
	localparam int VEC_COUNT       = 21;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + VEC_COUNT * (WAIT_CYCLES + 4) + 50;

	typedef struct packed {
		period_t    value;
		note_name_e note;
		tone_e      tone;
		logic       jitter;   // Add random offset to the period
	} vector_t;

	logic         clk;
	logic         reset;
	logic         period_valid;
	period_t      period;
	logic         result_valid;
	note_result_t result;

	int seed        = 97;
	int check_count = 0;
	int error_count = 0;

	// --------------------------------------------------
	// Stimulus and expected results
	// --------------------------------------------------
	vector_t vectors [VEC_COUNT] = '{
		'{34'd2273000,  NOTE_A,    ON_PITCH,     1'b1},   // A4
		'{34'd15289000, NOTE_C,    ON_PITCH,     1'b1},   // C2
		'{34'd1517000,  NOTE_E,    ON_PITCH,     1'b1},   // E5
		'{34'd11454000, NOTE_F,    ON_PITCH,     1'b1},   // F2
		'{34'd24285000, NOTE_E,    ON_PITCH,     1'b0},   // Above E1
		'{34'd3780000,  NOTE_C,    SHARP_1,      1'b0},   // C4 toward Db4
		'{34'd3700000,  NOTE_C,    SHARP_2,      1'b0},
		'{34'd3640000,  NOTE_C,    SHARP_3,      1'b0},
		'{34'd2995000,  NOTE_E,    SHARP_1,      1'b0},   // E4 toward F4
		'{34'd2950000,  NOTE_E,    SHARP_2,      1'b0},
		'{34'd2900000,  NOTE_E,    SHARP_3,      1'b0},
		'{34'd8000000,  NOTE_B,    SHARP_1,      1'b0},   // B2 toward C3
		'{34'd7900000,  NOTE_B,    SHARP_2,      1'b0},
		'{34'd7700000,  NOTE_B,    SHARP_3,      1'b0},
		'{34'd4250000,  NOTE_B,    FLAT_3,       1'b0},   // Bb3 toward B3
		'{34'd4170000,  NOTE_B,    FLAT_2,       1'b0},
		'{34'd4080000,  NOTE_B,    FLAT_1,       1'b0},
		'{34'd5117000,  NOTE_G,    ON_PITCH,     1'b0},   // Window beats region
		'{34'd24300000, NOTE_NONE, TONE_DEFAULT, 1'b0},
		'{34'd1496000,  NOTE_NONE, TONE_DEFAULT, 1'b0},
		'{34'd0,        NOTE_NONE, TONE_DEFAULT, 1'b0}
	};

	note_finder dut_i (
		.clk          (clk),
		.reset        (reset),
		.period_valid (period_valid),
		.period       (period),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the test sequence completed");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic compare(input int actual, input int expected, input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error at %0d ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	// Single-cycle strobe with the period
	task automatic send_period(input period_t value);
		@(posedge clk);
		period       <= value;
		period_valid <= 1'b1;
		@(posedge clk);
		period_valid <= 1'b0;
	endtask

	task automatic wait_result(output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_CYCLES) begin
			@(negedge clk);   // Outputs settled mid cycle
			cycles++;
			if (result_valid) seen = 1'b1;
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int      jitter;
		period_t stim;
		bit      seen;
		reset        = 1'b1;
		period_valid = 1'b0;
		period       = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare(int'(result_valid), 0, "result_valid after reset");
		compare(int'(result.note), int'(NOTE_NONE), "note after reset");
		compare(int'(result.tone), int'(TONE_DEFAULT), "tone after reset");

		for (int i = 0; i < VEC_COUNT; i++) begin
			stim = vectors[i].value;
			if (vectors[i].jitter) begin
				jitter = $random(seed) % JITTER_LIMIT;
				stim   = period_t'(longint'(vectors[i].value) + longint'(jitter));
			end
			send_period(stim);
			wait_result(seen);
			if (!seen) begin
				$display("No result_valid within %0d cycles for vector %0d", WAIT_CYCLES, i);
				error_count++;
				break;
			end
			compare(int'(result.note), int'(vectors[i].note), $sformatf("vector %0d note", i));
			compare(int'(result.tone), int'(vectors[i].tone), $sformatf("vector %0d tone", i));
			@(negedge clk);
			// One pulse only, result held
			compare(int'(result_valid), 0, $sformatf("vector %0d second pulse", i));
			compare(int'(result.note), int'(vectors[i].note), $sformatf("vector %0d held", i));
			compare(int'(result.tone), int'(vectors[i].tone),
				$sformatf("vector %0d tone held", i));
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: build.f
hw/tuner_pkg.sv
hw/pitch_table.sv
hw/scan_counter.sv
hw/scan_fsm.sv
hw/pitch_classifier.sv
hw/note_finder.sv
dv/note_finder_tb.sv

// File: Makefile
BIN := obj_dir/Vnote_finder_tb

$(BIN): build.f $(shell cat build.f)
	verilator --binary --timing --assert --top-module note_finder_tb -Mdir obj_dir -f build.f

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
